// File: logic/ddr3_settings.svh
`ifndef DDR3_SETTINGS_SVH
`define DDR3_SETTINGS_SVH

// geometry of a 1Gb x16 DDR3 part
`define DDR_ROW_BITS 13
`define DDR_BANK_BITS 3
`define DDR_COL_BITS 10

// column bits covered by one BL8 burst, never carried by a request
`define DDR_BURST_BITS 3

// burst-aligned request address, ordered {row, bank, column[9:3]}
`define DDR_ADDR_BITS (`DDR_ROW_BITS + `DDR_BANK_BITS + `DDR_COL_BITS - `DDR_BURST_BITS)

// data word and transaction id widths
`define DDR_WIDTH 32
`define DDR_REQID 4

// words per BL8 burst on this data path
`define DDR_BEATS 4

// reads that may be outstanding at the DDL
`define DDR_INFLIGHT 4

`endif

// File: logic/ddr3_pkg.sv
`include "ddr3_settings.svh"

package ddr3_pkg;

  // DDR3 command codes, {RAS#, CAS#, WE#}
  typedef enum logic [2:0] {
    CMD_MRS  = 3'b000,
    CMD_REF  = 3'b001,
    CMD_PRE  = 3'b010,
    CMD_ACT  = 3'b011,
    CMD_WR   = 3'b100,
    CMD_RD   = 3'b101,
    CMD_ZQCL = 3'b110,
    CMD_NOP  = 3'b111
  } ddl_cmd_e;

  // both read sequencers step through the same states, coded like their commands
  typedef enum logic [2:0] {
    ST_IDLE = 3'b111,
    ST_ACTV = 3'b011,
    ST_READ = 3'b101
  } rd_state_e;

  typedef logic [`DDR_WIDTH-1:0]     word_t;
  typedef logic [`DDR_REQID-1:0]     tid_t;
  typedef logic [`DDR_ADDR_BITS-1:0] req_addr_t;
  typedef logic [`DDR_BANK_BITS-1:0] bank_t;

  // column view of the address word, as read by RD
  typedef struct packed {
    logic [`DDR_ROW_BITS-`DDR_COL_BITS-2:0] rsvd;
    logic                                   ap;
    logic [`DDR_COL_BITS-1:0]               col;
  } ddl_col_t;

  // ACT reads the word as a row, RD as a column plus auto-precharge
  typedef union packed {
    logic [`DDR_ROW_BITS-1:0] row;
    ddl_col_t                 rd;
  } ddl_adr_u;

  // row field sits at the top of a request address
  function automatic ddl_adr_u adr_row(input req_addr_t addr);
    ddl_adr_u a;
    a.row = addr[`DDR_ADDR_BITS-1 -: `DDR_ROW_BITS];
    return a;
  endfunction

  function automatic bank_t adr_bank(input req_addr_t addr);
    return addr[`DDR_COL_BITS-`DDR_BURST_BITS +: `DDR_BANK_BITS];
  endfunction

  // burst offset bits of the column are zero, auto-precharge always on
  function automatic ddl_adr_u adr_col(input req_addr_t addr);
    ddl_adr_u a;
    a.rd.rsvd = '0;
    a.rd.ap   = 1'b1;
    a.rd.col  = {addr[`DDR_COL_BITS-`DDR_BURST_BITS-1:0], {`DDR_BURST_BITS{1'b0}}};
    return a;
  endfunction

endpackage

// File: logic/ddl_cmd_if.sv
`timescale 1ns/1ps

interface ddl_cmd_if import ddr3_pkg::*; ();

  // command request, transfers when req and rdy are both high
  logic     req;
  // set from an accepted ACT until its READ is taken
  logic     seq;
  ddl_cmd_e cmd;
  tid_t     tid;
  bank_t    ba;
  ddl_adr_u adr;
  // from the layer: accept, and refresh in progress
  logic     rdy;
  logic     refr;

  modport ctrl (
    output req, seq, cmd, tid, ba, adr,
    input  rdy, refr
  );

  modport layer (
    input  req, seq, cmd, tid, ba, adr,
    output rdy, refr
  );

  // watches issued commands only
  modport mon (
    input req, seq, cmd, tid, ba, adr, rdy, refr
  );

endinterface

// File: logic/ddl_rdata_if.sv
`timescale 1ns/1ps

interface ddl_rdata_if import ddr3_pkg::*; ();

  // one beat moves when valid and ready are both high
  logic  valid;
  logic  ready;
  // marks the final beat of a burst
  logic  last;
  word_t data;

  modport source (
    output valid, last, data,
    input  ready
  );

  modport sink (
    input  valid, last, data,
    output ready
  );

endinterface

// File: logic/ddr3_read_ctrl.sv
`timescale 1ns/1ps

module ddr3_read_ctrl import ddr3_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      req_valid_i,
  output logic      req_ready_o,
  input  req_addr_t req_addr_i,
  input  tid_t      req_id_i,
  ddl_cmd_if.ctrl   cmd_o
);

  rd_state_e state;
  logic      run_q;
  logic      take;
  req_addr_t addr_q;
  tid_t      tid_q;

  // hold off requests for the first cycle out of reset
  always_ff @(posedge clock) begin
    if (reset) begin
      run_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
    end
  end

  // no new request while the layer is refreshing
  assign req_ready_o = run_q && (state == ST_IDLE) && !cmd_o.refr;
  assign take = req_valid_i && req_ready_o;

  // request payload, kept until the READ is accepted
  always_ff @(posedge clock) begin
    if (take) begin
      addr_q <= req_addr_i;
      tid_q  <= req_id_i;
    end
  end

  // rdy is masked while the fast path owns the channel, so we just wait
  always_ff @(posedge clock) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (take) begin
            state <= ST_ACTV;
          end
        end
        ST_ACTV: begin
          if (cmd_o.rdy) begin
            state <= ST_READ;
          end
        end
        ST_READ: begin
          if (cmd_o.rdy) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  always_comb begin
    cmd_o.req = 1'b0;
    cmd_o.seq = 1'b0;
    cmd_o.cmd = CMD_NOP;
    cmd_o.adr = adr_row(addr_q);
    case (state)
      ST_ACTV: begin
        cmd_o.req = 1'b1;
        cmd_o.cmd = CMD_ACT;
      end
      // row is open, the sequence must not be split from here
      ST_READ: begin
        cmd_o.req = 1'b1;
        cmd_o.seq = 1'b1;
        cmd_o.cmd = CMD_RD;
        cmd_o.adr = adr_col(addr_q);
      end
      default: begin
        cmd_o.req = 1'b0;
      end
    endcase
  end

  assign cmd_o.ba  = adr_bank(addr_q);
  assign cmd_o.tid = tid_q;

endmodule

// File: logic/ddr3_bypass.sv
`timescale 1ns/1ps

module ddr3_bypass import ddr3_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      axi_arvalid_i,
  output logic      axi_arready_o,
  input  req_addr_t axi_araddr_i,
  input  tid_t      axi_arid_i,
  // origin FIFO in the steering block is full
  input  logic      blocked_i,
  // the DDL channel carries a fast-path command this cycle
  output logic      fast_o,
  ddl_cmd_if.layer  ctl_cmd,
  ddl_cmd_if.ctrl   ddl_cmd
);

  rd_state_e state;
  req_addr_t addr_q;
  tid_t      tid_q;
  req_addr_t addr_w;
  tid_t      tid_w;
  logic      take;
  logic      own;
  logic      hold;
  logic      go;
  logic      byp_seq;
  ddl_cmd_e  byp_cmd;
  ddl_adr_u  byp_adr;
  ddl_cmd_e  mux_cmd;

  // channel is free when the controller is not between ACT and READ
  assign take = (state == ST_IDLE) && axi_arvalid_i && !ctl_cmd.seq && !ddl_cmd.refr;
  assign own  = take || (state != ST_IDLE);
  assign fast_o = own;

  // ACT goes out in the cycle we take the channel, straight from the AXI address
  assign addr_w = (state == ST_IDLE) ? axi_araddr_i : addr_q;
  assign tid_w  = (state == ST_IDLE) ? axi_arid_i : tid_q;

  // captured while idle, the AXI master holds it until arready anyway
  always_ff @(posedge clock) begin
    if (state == ST_IDLE) begin
      addr_q <= axi_araddr_i;
      tid_q  <= axi_arid_i;
    end
  end

  always_comb begin
    byp_seq = 1'b0;
    byp_cmd = CMD_ACT;
    byp_adr = adr_row(addr_w);
    if (state == ST_READ) begin
      byp_seq = 1'b1;
      byp_cmd = CMD_RD;
      byp_adr = adr_col(addr_w);
    end
  end

  // command toward the DDL, ours or the controller's
  assign mux_cmd = own ? byp_cmd : ctl_cmd.cmd;

  // a READ is held back while its burst has no slot for routing
  assign hold = blocked_i && (mux_cmd == CMD_RD);
  assign go   = ddl_cmd.rdy && !hold;

  assign ddl_cmd.req = (own || ctl_cmd.req) && !hold;
  assign ddl_cmd.seq = own ? byp_seq : ctl_cmd.seq;
  assign ddl_cmd.cmd = mux_cmd;
  assign ddl_cmd.tid = own ? tid_w : ctl_cmd.tid;
  assign ddl_cmd.ba  = own ? adr_bank(addr_w) : ctl_cmd.ba;
  assign ddl_cmd.adr = own ? byp_adr : ctl_cmd.adr;

  // controller only sees rdy when it has the channel
  assign ctl_cmd.rdy  = go && !own;
  // refresh is always visible to the controller
  assign ctl_cmd.refr = ddl_cmd.refr;

  // address phase ends with the READ handshake
  assign axi_arready_o = (state == ST_READ) && go;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (take) begin
            // ACT may be accepted in the same cycle
            state <= go ? ST_READ : ST_ACTV;
          end
        end
        ST_ACTV: begin
          if (go) begin
            state <= ST_READ;
          end
        end
        ST_READ: begin
          if (go) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

// File: logic/ddr3_rdata_steer.sv
`timescale 1ns/1ps
`include "ddr3_settings.svh"

module ddr3_rdata_steer import ddr3_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  ddl_cmd_if.mon      issued,
  // issued command came from the fast path
  input  logic        fast_i,
  output logic        blocked_o,
  ddl_rdata_if.sink   ddl_r,
  ddl_rdata_if.source ctl_r,
  output logic        axi_rvalid_o,
  input  logic        axi_rready_i,
  output logic        axi_rlast_o,
  output logic [1:0]  axi_rresp_o,
  output tid_t        axi_rid_o,
  output word_t       axi_rdata_o,
  output tid_t        ctl_rid_o
);

  localparam int DEPTH = `DDR_INFLIGHT;
  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  // origin and id of each READ at the DDL, oldest at rd_ptr
  logic          fast_q [DEPTH];
  tid_t          tid_q [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          push;
  logic          pop;
  logic          empty;
  logic          head_fast;

  function automatic logic [PW-1:0] ptr_next(input logic [PW-1:0] p);
    return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign push = issued.req && issued.rdy && (issued.cmd == CMD_RD);
  // one entry per burst, released on its last beat
  assign pop = ddl_r.valid && ddl_r.ready && ddl_r.last;

  assign empty = (count == '0);
  assign blocked_o = (count == CW'(DEPTH));
  assign head_fast = fast_q[rd_ptr];

  always_ff @(posedge clock) begin
    if (push) begin
      fast_q[wr_ptr] <= fast_i;
      tid_q[wr_ptr]  <= issued.tid;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // beats pass straight through to the port at the head
  assign axi_rvalid_o = ddl_r.valid && !empty && head_fast;
  assign axi_rlast_o  = ddl_r.last;
  assign axi_rdata_o  = ddl_r.data;
  assign axi_rid_o    = tid_q[rd_ptr];
  // always OKAY
  assign axi_rresp_o  = 2'b00;

  assign ctl_r.valid = ddl_r.valid && !empty && !head_fast;
  assign ctl_r.last  = ddl_r.last;
  assign ctl_r.data  = ddl_r.data;
  assign ctl_rid_o   = tid_q[rd_ptr];

  // a slow consumer stalls the DDL instead of dropping beats
  assign ddl_r.ready = !empty && (head_fast ? axi_rready_i : ctl_r.ready);

endmodule

// File: logic/ddr3_fastpath_top.sv
`timescale 1ns/1ps

module ddr3_fastpath_top import ddr3_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  // AXI read address
  input  logic       axi_arvalid_i,
  output logic       axi_arready_o,
  input  req_addr_t  axi_araddr_i,
  input  tid_t       axi_arid_i,
  // AXI read data
  output logic       axi_rvalid_o,
  input  logic       axi_rready_i,
  output logic       axi_rlast_o,
  output logic [1:0] axi_rresp_o,
  output tid_t       axi_rid_o,
  output word_t      axi_rdata_o,
  // ordinary requests
  input  logic       req_valid_i,
  output logic       req_ready_o,
  input  req_addr_t  req_addr_i,
  input  tid_t       req_id_i,
  // ordinary read data
  output logic       ctl_rvalid_o,
  input  logic       ctl_rready_i,
  output logic       ctl_rlast_o,
  output word_t      ctl_rdata_o,
  output tid_t       ctl_rid_o,
  // DDL commands
  output logic       byp_req_o,
  output logic       byp_seq_o,
  input  logic       byp_rdy_i,
  input  logic       byp_ref_i,
  output ddl_cmd_e   byp_cmd_o,
  output tid_t       byp_tid_o,
  output bank_t      byp_ba_o,
  output ddl_adr_u   byp_adr_o,
  // DDL read data
  input  logic       ddl_rvalid_i,
  output logic       ddl_rready_o,
  input  logic       ddl_rlast_i,
  input  word_t      ddl_rdata_i
);

  logic fast;
  logic blocked;

  ddl_cmd_if   ctl_cmd ();
  ddl_cmd_if   ddl_cmd ();
  ddl_rdata_if ddl_r ();
  ddl_rdata_if ctl_r ();

  // DDL command port
  assign byp_req_o = ddl_cmd.req;
  assign byp_seq_o = ddl_cmd.seq;
  assign byp_cmd_o = ddl_cmd.cmd;
  assign byp_tid_o = ddl_cmd.tid;
  assign byp_ba_o  = ddl_cmd.ba;
  assign byp_adr_o = ddl_cmd.adr;
  assign ddl_cmd.rdy  = byp_rdy_i;
  assign ddl_cmd.refr = byp_ref_i;

  // DDL read data in, controller read data out
  assign ddl_r.valid  = ddl_rvalid_i;
  assign ddl_r.last   = ddl_rlast_i;
  assign ddl_r.data   = ddl_rdata_i;
  assign ddl_rready_o = ddl_r.ready;
  assign ctl_rvalid_o = ctl_r.valid;
  assign ctl_rlast_o  = ctl_r.last;
  assign ctl_rdata_o  = ctl_r.data;
  assign ctl_r.ready  = ctl_rready_i;

  ddr3_read_ctrl u_read_ctrl (
    .clock       (clock),
    .reset       (reset),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_addr_i  (req_addr_i),
    .req_id_i    (req_id_i),
    .cmd_o       (ctl_cmd)
  );

  ddr3_bypass u_bypass (
    .clock         (clock),
    .reset         (reset),
    .axi_arvalid_i (axi_arvalid_i),
    .axi_arready_o (axi_arready_o),
    .axi_araddr_i  (axi_araddr_i),
    .axi_arid_i    (axi_arid_i),
    .blocked_i     (blocked),
    .fast_o        (fast),
    .ctl_cmd       (ctl_cmd),
    .ddl_cmd       (ddl_cmd)
  );

  ddr3_rdata_steer u_rdata_steer (
    .clock        (clock),
    .reset        (reset),
    .issued       (ddl_cmd),
    .fast_i       (fast),
    .blocked_o    (blocked),
    .ddl_r        (ddl_r),
    .ctl_r        (ctl_r),
    .axi_rvalid_o (axi_rvalid_o),
    .axi_rready_i (axi_rready_i),
    .axi_rlast_o  (axi_rlast_o),
    .axi_rresp_o  (axi_rresp_o),
    .axi_rid_o    (axi_rid_o),
    .axi_rdata_o  (axi_rdata_o),
    .ctl_rid_o    (ctl_rid_o)
  );

endmodule

// File: testbench/ddl_model.sv
`timescale 1ns/1ps
`include "ddr3_settings.svh"

module ddl_model import ddr3_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  // refresh window requested by the testbench
  input  logic     ref_hold_i,
  input  logic     cmd_req_i,
  input  ddl_cmd_e cmd_i,
  input  tid_t     tid_i,
  input  bank_t    ba_i,
  input  ddl_adr_u adr_i,
  output logic     rdy_o,
  output logic     ref_o,
  output logic     rvalid_o,
  input  logic     rready_i,
  output logic     rlast_o,
  output word_t    rdata_o
);

  integer seed = 60;
  logic [`DDR_ROW_BITS-1:0] open_row [1 << `DDR_BANK_BITS];
  // bursts owed to the controller, in issue order
  req_addr_t rd_q [$];
  int        beat;

  // accepted commands, read by the tests
  ddl_cmd_e  log_cmd [$];
  bank_t     log_ba [$];
  ddl_adr_u  log_adr [$];
  tid_t      log_tid [$];
  int        act_in_ref;

  // memory contents follow the address, word k of burst A holds A*16+k
  function automatic word_t stored_word(input req_addr_t addr, input int k);
    return word_t'(addr) * 16 + word_t'(k);
  endfunction

  assign ref_o = ref_hold_i;

  initial begin
    rdy_o      = 1'b0;
    rvalid_o   = 1'b0;
    rlast_o    = 1'b0;
    rdata_o    = '0;
    beat       = 0;
    act_in_ref = 0;
  end

  always @(posedge clock) begin
    if (reset) begin
      rd_q.delete();
      beat = 0;
    end else begin
      if (cmd_req_i && rdy_o) begin
        log_cmd.push_back(cmd_i);
        log_ba.push_back(ba_i);
        log_adr.push_back(adr_i);
        log_tid.push_back(tid_i);
        if (cmd_i == CMD_ACT) begin
          open_row[ba_i] = adr_i.row;
          if (ref_o) begin
            act_in_ref++;
          end
        end
        // burst address rebuilt from the open row and the column
        if (cmd_i == CMD_RD) begin
          rd_q.push_back({open_row[ba_i], ba_i,
                          adr_i.rd.col[`DDR_COL_BITS-1:`DDR_BURST_BITS]});
        end
      end
      if (rvalid_o && rready_i) begin
        if (rlast_o) begin
          void'(rd_q.pop_front());
          beat = 0;
        end else begin
          beat++;
        end
      end
    end
    #1;
    // accept about three commands in four
    rdy_o    = !reset && (($random(seed) & 3) != 0);
    rvalid_o = !reset && (rd_q.size() != 0);
    rlast_o  = (beat == `DDR_BEATS - 1);
    rdata_o  = '0;
    if (rvalid_o) begin
      rdata_o = stored_word(rd_q[0], beat);
    end
  end

endmodule

// File: testbench/tb_ddr3_fastpath.sv
`timescale 1ns/1ps
`include "ddr3_settings.svh"

module tb_ddr3_fastpath import ddr3_pkg::*; ();

  // about ten times the longest test
  localparam int TIMEOUT_CYCLES = 3000;

  logic clock;
  logic reset;
  logic axi_arvalid_i, axi_arready_o, axi_rvalid_o, axi_rready_i, axi_rlast_o;
  req_addr_t axi_araddr_i, req_addr_i;
  tid_t axi_arid_i, axi_rid_o, req_id_i, ctl_rid_o, byp_tid_o;
  logic [1:0] axi_rresp_o;
  word_t axi_rdata_o, ctl_rdata_o, ddl_rdata_i;
  logic req_valid_i, req_ready_o, ctl_rvalid_o, ctl_rready_i, ctl_rlast_o;
  logic byp_req_o, byp_seq_o, byp_rdy_i, byp_ref_i;
  ddl_cmd_e byp_cmd_o;
  bank_t byp_ba_o;
  ddl_adr_u byp_adr_o;
  logic ddl_rvalid_i, ddl_rready_o, ddl_rlast_i;
  logic ref_hold;
  logic bp_on;
  // an accepted ACT still waits for its READ
  logic seq_open = 1'b0;

  integer seed = 60;
  int errors = 0;
  int checks = 0;
  int cycles = 0;
  int axi_beat = 0;
  int ctl_beat = 0;
  string tname = "reset";
  // bursts still owed on each port in request order
  req_addr_t exp_axi_addr [$];
  tid_t      exp_axi_id [$];
  req_addr_t exp_ctl_addr [$];
  tid_t      exp_ctl_id [$];

  ddr3_fastpath_top dut (
    .clock(clock), .reset(reset),
    .axi_arvalid_i(axi_arvalid_i), .axi_arready_o(axi_arready_o),
    .axi_araddr_i(axi_araddr_i), .axi_arid_i(axi_arid_i),
    .axi_rvalid_o(axi_rvalid_o), .axi_rready_i(axi_rready_i), .axi_rlast_o(axi_rlast_o),
    .axi_rresp_o(axi_rresp_o), .axi_rid_o(axi_rid_o), .axi_rdata_o(axi_rdata_o),
    .req_valid_i(req_valid_i), .req_ready_o(req_ready_o),
    .req_addr_i(req_addr_i), .req_id_i(req_id_i),
    .ctl_rvalid_o(ctl_rvalid_o), .ctl_rready_i(ctl_rready_i), .ctl_rlast_o(ctl_rlast_o),
    .ctl_rdata_o(ctl_rdata_o), .ctl_rid_o(ctl_rid_o),
    .byp_req_o(byp_req_o), .byp_seq_o(byp_seq_o), .byp_rdy_i(byp_rdy_i),
    .byp_ref_i(byp_ref_i), .byp_cmd_o(byp_cmd_o), .byp_tid_o(byp_tid_o),
    .byp_ba_o(byp_ba_o), .byp_adr_o(byp_adr_o),
    .ddl_rvalid_i(ddl_rvalid_i), .ddl_rready_o(ddl_rready_o),
    .ddl_rlast_i(ddl_rlast_i), .ddl_rdata_i(ddl_rdata_i)
  );

  ddl_model ddl (
    .clock(clock), .reset(reset), .ref_hold_i(ref_hold),
    .cmd_req_i(byp_req_o), .cmd_i(byp_cmd_o), .tid_i(byp_tid_o),
    .ba_i(byp_ba_o), .adr_i(byp_adr_o), .rdy_o(byp_rdy_i), .ref_o(byp_ref_i),
    .rvalid_o(ddl_rvalid_i), .rready_i(ddl_rready_o),
    .rlast_o(ddl_rlast_i), .rdata_o(ddl_rdata_i)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  task automatic check_word(input string name, input word_t exp, input word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s: expected %0h, actual %0h", name, exp, act);
    end
  endtask

  task automatic check_tid(input string name, input tid_t exp, input tid_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s: expected id %0h, actual id %0h", name, exp, act);
    end
  endtask

  task automatic check_cmd(input string name, input ddl_cmd_e exp, input ddl_cmd_e act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s: expected %s, actual %s (%0h)", name, exp.name(), act.name(), act);
    end
  endtask

  task automatic check_bank(input string name, input bank_t exp, input bank_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s: expected bank %0h, actual bank %0h", name, exp, act);
    end
  endtask

  task automatic check_adr(input string name, input ddl_adr_u exp, input ddl_adr_u act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s: expected adr %0h, actual adr %0h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s: expected flag %0b, actual flag %0b", name, exp, act);
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s: expected resp %0h, actual resp %0h", name, exp, act);
    end
  endtask

  // word k of the burst at address A is A*16+k
  function automatic word_t burst_word(input req_addr_t addr, input int k);
    return word_t'(addr) * 16 + word_t'(k);
  endfunction

  // every AXI beat must belong to the oldest AXI burst
  always @(posedge clock) begin
    if (!reset && axi_rvalid_o && axi_rready_i) begin
      if (exp_axi_addr.size() == 0) begin
        errors++;
        $display("%s: beat on the AXI read data port with no AXI read pending", tname);
      end else begin
        check_word(tname, burst_word(exp_axi_addr[0], axi_beat), axi_rdata_o);
        check_tid(tname, exp_axi_id[0], axi_rid_o);
        check_flag(tname, axi_beat == `DDR_BEATS - 1, axi_rlast_o);
        check_resp(tname, 2'b00, axi_rresp_o);
        axi_beat++;
        if (axi_rlast_o) begin
          void'(exp_axi_addr.pop_front());
          void'(exp_axi_id.pop_front());
          axi_beat = 0;
        end
      end
    end
  end

  // controller data monitor
  always @(posedge clock) begin
    if (!reset && ctl_rvalid_o && ctl_rready_i) begin
      if (exp_ctl_addr.size() == 0) begin
        errors++;
        $display("%s: beat on the controller data port with no ordinary read pending", tname);
      end else begin
        check_word(tname, burst_word(exp_ctl_addr[0], ctl_beat), ctl_rdata_o);
        check_tid(tname, exp_ctl_id[0], ctl_rid_o);
        check_flag(tname, ctl_beat == `DDR_BEATS - 1, ctl_rlast_o);
        ctl_beat++;
        if (ctl_rlast_o) begin
          void'(exp_ctl_addr.pop_front());
          void'(exp_ctl_id.pop_front());
          ctl_beat = 0;
        end
      end
    end
  end

  // seq spans an accepted ACT up to the cycle its READ is accepted
  always @(posedge clock) begin
    if (!reset) begin
      check_flag({tname, "/seq"}, seq_open, byp_seq_o);
      if (byp_req_o && byp_rdy_i && byp_cmd_o == CMD_ACT) begin
        seq_open = 1'b1;
      end else if (byp_req_o && byp_rdy_i && byp_cmd_o == CMD_RD) begin
        seq_open = 1'b0;
      end
    end
  end

  // random rready on both ports during the back-pressure test
  always @(posedge clock) begin
    #1;
    if (bp_on) begin
      axi_rready_i = $random(seed);
      ctl_rready_i = $random(seed);
    end else begin
      axi_rready_i = 1'b1;
      ctl_rready_i = 1'b1;
    end
  end

  initial begin
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clock);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

  task automatic axi_read(input req_addr_t addr, input tid_t id);
    exp_axi_addr.push_back(addr);
    exp_axi_id.push_back(id);
    @(posedge clock);
    #1;
    axi_arvalid_i = 1'b1;
    axi_araddr_i  = addr;
    axi_arid_i    = id;
    // arready pulses in the cycle the READ is accepted
    do @(posedge clock); while (!axi_arready_o);
    // that READ carries the AXI id
    check_flag({tname, "/arready"}, 1'b1, byp_req_o && byp_rdy_i);
    check_cmd(tname, CMD_RD, byp_cmd_o);
    check_tid(tname, id, byp_tid_o);
    #1;
    axi_arvalid_i = 1'b0;
  endtask

  task automatic ctl_read(input req_addr_t addr, input tid_t id);
    exp_ctl_addr.push_back(addr);
    exp_ctl_id.push_back(id);
    @(posedge clock);
    #1;
    req_valid_i = 1'b1;
    req_addr_i  = addr;
    req_id_i    = id;
    do @(posedge clock); while (!req_ready_o);
    #1;
    req_valid_i = 1'b0;
  endtask

  // wait until every requested burst came back
  task automatic drain();
    while (exp_axi_addr.size() != 0 || exp_ctl_addr.size() != 0) begin
      @(posedge clock);
    end
    repeat (2) @(posedge clock);
  endtask

  task automatic clear_log();
    ddl.log_cmd.delete();
    ddl.log_ba.delete();
    ddl.log_adr.delete();
    ddl.log_tid.delete();
  endtask

  // every accepted ACT is followed directly by its READ
  task automatic check_pairs();
    if (ddl.log_cmd.size() % 2 != 0) begin
      errors++;
      $display("%s: odd number of accepted commands, a sequence was split", tname);
    end
    for (int i = 0; i + 1 < ddl.log_cmd.size(); i += 2) begin
      check_cmd(tname, CMD_ACT, ddl.log_cmd[i]);
      check_cmd(tname, CMD_RD, ddl.log_cmd[i + 1]);
      check_bank(tname, ddl.log_ba[i], ddl.log_ba[i + 1]);
      check_tid(tname, ddl.log_tid[i], ddl.log_tid[i + 1]);
    end
  endtask

  task automatic single_fast_read();
    tname = "single_read";
    axi_read(23'h12a5c, 4'h3);
    drain();
  endtask

  task automatic fast_cmd_sequence();
    req_addr_t addr;
    ddl_adr_u  row_w;
    ddl_adr_u  col_w;
    tname = "cmd_sequence";
    // 23'h5b3e7 splits into row 13'h16c, bank 7 and column 7'h67
    addr = 23'h5b3e7;
    row_w.row     = 13'h016c;
    col_w.rd.rsvd = '0;
    col_w.rd.ap   = 1'b1;
    col_w.rd.col  = 10'h338;
    clear_log();
    axi_read(addr, 4'h9);
    drain();
    if (ddl.log_cmd.size() != 2) begin
      errors++;
      $display("%s: %0d commands accepted instead of ACT and RD", tname, ddl.log_cmd.size());
    end else begin
      check_cmd(tname, CMD_ACT, ddl.log_cmd[0]);
      check_bank(tname, 3'h7, ddl.log_ba[0]);
      check_adr(tname, row_w, ddl.log_adr[0]);
      check_cmd(tname, CMD_RD, ddl.log_cmd[1]);
      check_bank(tname, 3'h7, ddl.log_ba[1]);
      check_adr(tname, col_w, ddl.log_adr[1]);
    end
  endtask

  task automatic ordinary_read();
    tname = "ordinary_read";
    clear_log();
    ctl_read(23'h2c0f1, 4'h6);
    drain();
    check_pairs();
  endtask

  task automatic interleave_reads();
    tname = "interleave";
    clear_log();
    // fast read arrives while the ordinary ACT/RD pair is under way
    ctl_read(23'h01234, 4'h1);
    axi_read(23'h04321, 4'h2);
    fork
      for (int i = 0; i < 3; i++) begin
        axi_read(23'h10000 + 23'(i * 37), tid_t'(8 + i));
      end
      for (int i = 0; i < 3; i++) begin
        ctl_read(23'h20000 + 23'(i * 91), tid_t'(4 + i));
      end
    join
    drain();
    check_pairs();
  endtask

  task automatic refresh_window();
    tname = "refresh";
    clear_log();
    @(posedge clock);
    #1;
    ref_hold = 1'b1;
    fork
      axi_read(23'h3a001, 4'hc);
      ctl_read(23'h3a102, 4'hd);
      begin
        repeat (20) @(posedge clock);
        #1;
        if (ddl.log_cmd.size() != 0) begin
          errors++;
          $display("%s: commands were accepted while refresh was high", tname);
        end
        ref_hold = 1'b0;
      end
    join
    drain();
    if (ddl.act_in_ref != 0) begin
      errors++;
      $display("%s: %0d ACT accepted during refresh", tname, ddl.act_in_ref);
    end
    check_pairs();
  endtask

  task automatic rready_backpressure();
    tname = "backpressure";
    clear_log();
    bp_on = 1'b1;
    fork
      for (int i = 0; i < 4; i++) begin
        axi_read(req_addr_t'($random(seed)), tid_t'(i));
      end
      for (int i = 0; i < 4; i++) begin
        ctl_read(req_addr_t'($random(seed)), tid_t'(12 + i));
      end
    join
    drain();
    bp_on = 1'b0;
    check_pairs();
  endtask

  initial begin
    reset         = 1'b1;
    axi_arvalid_i = 1'b0;
    axi_araddr_i  = '0;
    axi_arid_i    = '0;
    axi_rready_i  = 1'b1;
    req_valid_i   = 1'b0;
    req_addr_i    = '0;
    req_id_i      = '0;
    ctl_rready_i  = 1'b1;
    ref_hold      = 1'b0;
    bp_on         = 1'b0;
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;
    single_fast_read();
    fast_cmd_sequence();
    ordinary_read();
    interleave_reads();
    refresh_window();
    rready_backpressure();
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+logic
logic/ddr3_pkg.sv
logic/ddl_cmd_if.sv
logic/ddl_rdata_if.sv
logic/ddr3_read_ctrl.sv
logic/ddr3_bypass.sv
logic/ddr3_rdata_steer.sv
logic/ddr3_fastpath_top.sv
testbench/ddl_model.sv
testbench/tb_ddr3_fastpath.sv
